//--- source/pkt_pkg.sv
`default_nettype none

package pkt_pkg;

    // Beat geometry
    localparam int DATA_BYTES = 4;
    // Unused trailing bytes, valid on eop only
    localparam int MTY_WID = 2;

    // Metadata
    localparam int IN_META_WID = 3;
    localparam int NUM_PORTS = 2;
    localparam int PORT_WID = 1;
    localparam int OUT_META_WID = PORT_WID + IN_META_WID;

    // Per-port buffering
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_WID = 4;

    typedef logic [DATA_BYTES*8-1:0] pkt_data_t;
    typedef logic [MTY_WID-1:0]      pkt_mty_t;
    typedef logic [IN_META_WID-1:0]  in_meta_t;
    // Source port in the top bit
    typedef logic [OUT_META_WID-1:0] out_meta_t;
    typedef logic [PORT_WID-1:0]     port_id_t;

    typedef enum logic {
        IDLE,
        IN_PACKET
    } merge_state_t;

endpackage : pkt_pkg

`default_nettype wire

//--- source/packet_intf.sv
`timescale 1ns/1ps
`default_nettype none

interface packet_intf
    import pkt_pkg::*;
();
    logic      vld;
    logic      rdy;
    pkt_data_t data;
    logic      eop;
    pkt_mty_t  mty;
    logic      err;
    in_meta_t  meta;

    // Sender side
    modport tx(
        output vld,
        input  rdy,
        output data,
        output eop,
        output mty,
        output err,
        output meta
    );

    // Receiver side
    modport rx(
        input  vld,
        output rdy,
        input  data,
        input  eop,
        input  mty,
        input  err,
        input  meta
    );

endinterface : packet_intf

`default_nettype wire

//--- source/packet_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module packet_fifo
    import pkt_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      in_vld,
    output logic      in_rdy,
    input  pkt_data_t in_data,
    input  logic      in_eop,
    input  pkt_mty_t  in_mty,
    input  logic      in_err,
    input  in_meta_t  in_meta,
    packet_intf.tx    to_rx
);

    // Beat storage
    pkt_data_t data_mem [FIFO_DEPTH];
    logic      eop_mem  [FIFO_DEPTH];
    pkt_mty_t  mty_mem  [FIFO_DEPTH];
    logic      err_mem  [FIFO_DEPTH];
    in_meta_t  meta_mem [FIFO_DEPTH];

    logic [FIFO_PTR_WID-1:0] wr_ptr;
    logic [FIFO_PTR_WID-1:0] rd_ptr;
    // One bit wider than the pointers to reach a full count
    logic [FIFO_PTR_WID:0]   count;
    logic                    push;
    logic                    pop;

    // Ready from state only, never from in_vld
    assign in_rdy = (count < (FIFO_PTR_WID + 1)'(FIFO_DEPTH));
    assign push   = in_vld && in_rdy;
    assign pop    = to_rx.vld && to_rx.rdy;

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= in_data;
            eop_mem[wr_ptr]  <= in_eop;
            mty_mem[wr_ptr]  <= in_mty;
            err_mem[wr_ptr]  <= in_err;
            meta_mem[wr_ptr] <= in_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head beat straight from the storage flops
    assign to_rx.vld  = (count != '0);
    assign to_rx.data = data_mem[rd_ptr];
    assign to_rx.eop  = eop_mem[rd_ptr];
    assign to_rx.mty  = mty_mem[rd_ptr];
    assign to_rx.err  = err_mem[rd_ptr];
    assign to_rx.meta = meta_mem[rd_ptr];

    // A full FIFO must not take another beat
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (reset)
        (count == (FIFO_PTR_WID + 1)'(FIFO_DEPTH)) |=> (wr_ptr == $past(wr_ptr))
    ) else $error("packet_fifo: write while full");

    a_count_range: assert property (
        @(posedge clk) disable iff (reset)
        (count <= (FIFO_PTR_WID + 1)'(FIFO_DEPTH))
    ) else $error("packet_fifo: count out of range");

    // Pointer distance tracks the count
    a_ptr_consistent: assert property (
        @(posedge clk) disable iff (reset)
        ((wr_ptr - rd_ptr) == count[FIFO_PTR_WID-1:0])
    ) else $error("packet_fifo: pointers disagree with count");

endmodule : packet_fifo

`default_nettype wire

//--- source/packet_merge.sv
`timescale 1ns/1ps
`default_nettype none

module packet_merge
    import pkt_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    packet_intf.rx    from_tx0,
    packet_intf.rx    from_tx1,
    output logic      out_vld,
    input  logic      out_rdy,
    output pkt_data_t out_data,
    output logic      out_eop,
    output pkt_mty_t  out_mty,
    output logic      out_err,
    output out_meta_t out_meta
);

    logic      port_vld  [NUM_PORTS];
    pkt_data_t port_data [NUM_PORTS];
    logic      port_eop  [NUM_PORTS];
    pkt_mty_t  port_mty  [NUM_PORTS];
    logic      port_err  [NUM_PORTS];
    in_meta_t  port_meta [NUM_PORTS];

    merge_state_t state;
    port_id_t     last_port;
    port_id_t     rr_pick;
    port_id_t     grant;
    logic         xfer;

    // Gather inputs into arrays indexed by port
    assign port_vld[0]  = from_tx0.vld;
    assign port_data[0] = from_tx0.data;
    assign port_eop[0]  = from_tx0.eop;
    assign port_mty[0]  = from_tx0.mty;
    assign port_err[0]  = from_tx0.err;
    assign port_meta[0] = from_tx0.meta;

    assign port_vld[1]  = from_tx1.vld;
    assign port_data[1] = from_tx1.data;
    assign port_eop[1]  = from_tx1.eop;
    assign port_mty[1]  = from_tx1.mty;
    assign port_err[1]  = from_tx1.err;
    assign port_meta[1] = from_tx1.meta;

    // Round robin, search starts after the last served port
    always_comb begin
        port_id_t cand;
        logic     found;
        rr_pick = last_port;
        found   = 1'b0;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            cand = port_id_t'((int'(last_port) + i) % NUM_PORTS);
            if (!found && port_vld[cand]) begin
                rr_pick = cand;
                found   = 1'b1;
            end
        end
    end

    // Locked once a packet's first beat is offered
    assign grant = (state == IN_PACKET) ? last_port : rr_pick;
    assign xfer  = out_vld && out_rdy;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            last_port <= port_id_t'(NUM_PORTS - 1);
        end else begin
            case (state)
                // A stalled first beat also locks the grant
                IDLE:      if (out_vld && !(out_rdy && out_eop)) state <= IN_PACKET;
                IN_PACKET: if (xfer && out_eop) state <= IDLE;
                default:   state <= IDLE;
            endcase
            if (out_vld) begin
                last_port <= grant;
            end
        end
    end

    assign out_vld  = port_vld[grant];
    assign out_data = port_data[grant];
    assign out_eop  = port_eop[grant];
    assign out_mty  = port_mty[grant];
    assign out_err  = port_err[grant];
    assign out_meta = {grant, port_meta[grant]};

    assign from_tx0.rdy = out_rdy && (grant == port_id_t'(0));
    assign from_tx1.rdy = out_rdy && (grant == port_id_t'(1));

    // Grant held from the first offered beat until eop transfers
    a_grant_held: assert property (
        @(posedge clk) disable iff (reset)
        ((state == IN_PACKET) || out_vld) && !(xfer && out_eop)
            |=> (grant == $past(grant))
    ) else $error("packet_merge: grant changed inside a packet");

    // Stalled output holds every field
    a_out_stable: assert property (
        @(posedge clk) disable iff (reset)
        out_vld && !out_rdy |=> out_vld && $stable(out_data) && $stable(out_eop)
            && $stable(out_mty) && $stable(out_err) && $stable(out_meta)
    ) else $error("packet_merge: output changed while stalled");

endmodule : packet_merge

`default_nettype wire

//--- source/pkt_aggregator.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_aggregator
    import pkt_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      in0_vld,
    output logic      in0_rdy,
    input  pkt_data_t in0_data,
    input  logic      in0_eop,
    input  pkt_mty_t  in0_mty,
    input  logic      in0_err,
    input  in_meta_t  in0_meta,

    input  logic      in1_vld,
    output logic      in1_rdy,
    input  pkt_data_t in1_data,
    input  logic      in1_eop,
    input  pkt_mty_t  in1_mty,
    input  logic      in1_err,
    input  in_meta_t  in1_meta,

    output logic      out_vld,
    input  logic      out_rdy,
    output pkt_data_t out_data,
    output logic      out_eop,
    output pkt_mty_t  out_mty,
    output logic      out_err,
    output out_meta_t out_meta
);

    // FIFO to merge links
    packet_intf fifo0_link ();
    packet_intf fifo1_link ();

    packet_fifo i_packet_fifo0 (
        .clk     (clk),
        .reset   (reset),
        .in_vld  (in0_vld),
        .in_rdy  (in0_rdy),
        .in_data (in0_data),
        .in_eop  (in0_eop),
        .in_mty  (in0_mty),
        .in_err  (in0_err),
        .in_meta (in0_meta),
        .to_rx   (fifo0_link.tx)
    );

    packet_fifo i_packet_fifo1 (
        .clk     (clk),
        .reset   (reset),
        .in_vld  (in1_vld),
        .in_rdy  (in1_rdy),
        .in_data (in1_data),
        .in_eop  (in1_eop),
        .in_mty  (in1_mty),
        .in_err  (in1_err),
        .in_meta (in1_meta),
        .to_rx   (fifo1_link.tx)
    );

    packet_merge i_packet_merge (
        .clk      (clk),
        .reset    (reset),
        .from_tx0 (fifo0_link.rx),
        .from_tx1 (fifo1_link.rx),
        .out_vld  (out_vld),
        .out_rdy  (out_rdy),
        .out_data (out_data),
        .out_eop  (out_eop),
        .out_mty  (out_mty),
        .out_err  (out_err),
        .out_meta (out_meta)
    );

endmodule : pkt_aggregator

`default_nettype wire

//--- verification/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // 8 ns period
    localparam int HALF_PERIOD_NS = 4;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD_NS clk = ~clk;
        end
    end

endmodule : tb_clock

`default_nettype wire

//--- verification/pkt_aggregator_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_aggregator_tb
    import pkt_pkg::*;
();

    // About 90 beats in all at four cycles each, plus a wide margin
    localparam int TIMEOUT_CYCLES = 4000;

    typedef struct packed {
        pkt_data_t data;
        logic      eop;
        pkt_mty_t  mty;
        logic      err;
        out_meta_t meta;
    } exp_beat_t;

    logic      clk;
    logic      reset;
    logic      in0_vld;
    logic      in0_rdy;
    pkt_data_t in0_data;
    logic      in0_eop;
    pkt_mty_t  in0_mty;
    logic      in0_err;
    in_meta_t  in0_meta;
    logic      in1_vld;
    logic      in1_rdy;
    pkt_data_t in1_data;
    logic      in1_eop;
    pkt_mty_t  in1_mty;
    logic      in1_err;
    in_meta_t  in1_meta;
    logic      out_vld;
    logic      out_rdy;
    pkt_data_t out_data;
    logic      out_eop;
    pkt_mty_t  out_mty;
    logic      out_err;
    out_meta_t out_meta;

    // Expected beats per input port, in send order
    exp_beat_t exp_q0 [$];
    exp_beat_t exp_q1 [$];
    // Source port of each packet as it leaves
    int        packet_ports [$];
    int        error_count;
    int        check_count;
    int        cycle_count;
    integer    seed;
    logic      traffic_done;

    tb_clock i_tb_clock (
        .clk (clk)
    );

    pkt_aggregator i_pkt_aggregator (.*);

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("ERROR: %s at %0t", what, $time);
    endtask

    function automatic logic port_ready(input int port);
        return (port == 0) ? in0_rdy : in1_rdy;
    endfunction

    task automatic drive_beat(input int port, input exp_beat_t beat);
        if (port == 0) begin
            in0_vld  = 1'b1;
            in0_data = beat.data;
            in0_eop  = beat.eop;
            in0_mty  = beat.mty;
            in0_err  = beat.err;
            in0_meta = beat.meta[IN_META_WID-1:0];
        end else begin
            in1_vld  = 1'b1;
            in1_data = beat.data;
            in1_eop  = beat.eop;
            in1_mty  = beat.mty;
            in1_err  = beat.err;
            in1_meta = beat.meta[IN_META_WID-1:0];
        end
    endtask

    // Leaves vld high after the last beat so packets can run back to back
    task automatic send_packet(input int port, input int len, input in_meta_t meta,
                               input pkt_mty_t last_mty, input int err_beat,
                               input logic [7:0] tag);
        exp_beat_t beat;
        for (int i = 0; i < len; i++) begin
            beat.data = {4'hA, 4'(port), tag, 16'(i)};
            beat.eop  = (i == len - 1);
            beat.mty  = beat.eop ? last_mty : '0;
            beat.err  = (i == err_beat);
            beat.meta = {port_id_t'(port), meta};
            @(negedge clk);
            drive_beat(port, beat);
            if (port == 0) begin
                exp_q0.push_back(beat);
            end else begin
                exp_q1.push_back(beat);
            end
            @(posedge clk);
            while (!port_ready(port)) begin
                @(posedge clk);
            end
        end
    endtask

    task automatic release_port(input int port);
        @(negedge clk);
        if (port == 0) begin
            in0_vld = 1'b0;
        end else begin
            in1_vld = 1'b0;
        end
    endtask

    task automatic wait_drain();
        while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic compare_beat(input exp_beat_t want);
        check_value("out_data", 64'(out_data), 64'(want.data));
        check_value("out_eop", 64'(out_eop), 64'(want.eop));
        check_value("out_mty", 64'(out_mty), 64'(want.mty));
        check_value("out_err", 64'(out_err), 64'(want.err));
        check_value("out_meta", 64'(out_meta), 64'(want.meta));
    endtask

    task automatic test_single_packet();
        $display("Test 1: single packet on port 0");
        @(negedge clk);
        out_rdy = 1'b1;
        fork
            begin
                send_packet(0, 3, 3'h5, 2'd2, -1, 8'h10);
                release_port(0);
            end
            begin
                @(posedge clk);
                while (!(in0_vld && in0_rdy)) begin
                    @(posedge clk);
                end
                check_value("out_vld", 64'(out_vld), 64'(0));
                // First beat visible right after the accepting edge
                @(negedge clk);
                check_value("out_vld", 64'(out_vld), 64'(1));
                check_value("out_meta", 64'(out_meta), 64'({1'b0, 3'h5}));
            end
        join
        wait_drain();
    endtask

    task automatic test_round_robin();
        $display("Test 2: round robin over both ports");
        apply_reset();
        packet_ports.delete();
        fork
            begin
                send_packet(0, 3, 3'h1, 2'd0, -1, 8'h20);
                send_packet(0, 5, 3'h2, 2'd1, -1, 8'h21);
                send_packet(0, 2, 3'h3, 2'd3, -1, 8'h22);
                send_packet(0, 4, 3'h4, 2'd2, -1, 8'h23);
                release_port(0);
            end
            begin
                send_packet(1, 4, 3'h6, 2'd1, -1, 8'h30);
                send_packet(1, 1, 3'h7, 2'd3, -1, 8'h31);
                send_packet(1, 6, 3'h0, 2'd2, -1, 8'h32);
                send_packet(1, 2, 3'h5, 2'd0, -1, 8'h33);
                release_port(1);
            end
        join
        wait_drain();
        check_value("packet_count", 64'(packet_ports.size()), 64'(8));
        foreach (packet_ports[i]) begin
            check_value("packet_port", 64'(packet_ports[i]), 64'(i % 2));
        end
    endtask

    task automatic test_random_backpressure();
        logic [31:0] rnd;
        $display("Test 3: random out_rdy with both ports busy");
        traffic_done = 1'b0;
        fork
            begin
                fork
                    begin
                        send_packet(0, 2, 3'h3, 2'd1, -1, 8'h60);
                        send_packet(0, 4, 3'h6, 2'd0, -1, 8'h61);
                        send_packet(0, 1, 3'h2, 2'd3, -1, 8'h62);
                        send_packet(0, 3, 3'h7, 2'd2, -1, 8'h63);
                        send_packet(0, 5, 3'h1, 2'd1, -1, 8'h64);
                        release_port(0);
                    end
                    begin
                        send_packet(1, 3, 3'h4, 2'd2, -1, 8'h70);
                        send_packet(1, 1, 3'h0, 2'd0, -1, 8'h71);
                        send_packet(1, 4, 3'h5, 2'd3, -1, 8'h72);
                        send_packet(1, 2, 3'h2, 2'd1, -1, 8'h73);
                        send_packet(1, 2, 3'h6, 2'd2, -1, 8'h74);
                        release_port(1);
                    end
                join
                traffic_done = 1'b1;
            end
            begin
                while (!traffic_done || exp_q0.size() != 0 || exp_q1.size() != 0) begin
                    @(negedge clk);
                    rnd     = $random(seed);
                    out_rdy = rnd[0];
                end
            end
        join
        @(negedge clk);
        out_rdy = 1'b1;
        wait_drain();
    endtask

    task automatic test_fifo_full();
        $display("Test 4: port 0 fills while out_rdy is low");
        @(negedge clk);
        out_rdy = 1'b0;
        send_packet(0, 16, 3'h6, 2'd1, -1, 8'h40);
        fork
            begin
                send_packet(0, 1, 3'h1, 2'd3, -1, 8'h41);
                release_port(0);
            end
            begin
                // Held beat must wait while the FIFO is full
                repeat (4) begin
                    @(negedge clk);
                    check_value("in0_rdy", 64'(in0_rdy), 64'(0));
                    // Port 1 is empty and stays ready
                    check_value("in1_rdy", 64'(in1_rdy), 64'(1));
                    check_value("out_vld", 64'(out_vld), 64'(1));
                end
                out_rdy = 1'b1;
            end
        join
        wait_drain();
    endtask

    task automatic test_err_and_mty();
        $display("Test 5: err and mty carried on both ports");
        fork
            begin
                send_packet(0, 3, 3'h7, 2'd3, 1, 8'h50);
                send_packet(0, 1, 3'h0, 2'd1, 0, 8'h51);
                send_packet(0, 2, 3'h2, 2'd2, 1, 8'h52);
                release_port(0);
            end
            begin
                send_packet(1, 2, 3'h3, 2'd0, 1, 8'h58);
                send_packet(1, 4, 3'h5, 2'd3, 3, 8'h59);
                send_packet(1, 1, 3'h1, 2'd2, 0, 8'h5A);
                release_port(1);
            end
        join
        wait_drain();
    endtask

    // Output monitor
    always @(posedge clk) begin
        port_id_t  port;
        exp_beat_t want;
        logic      in_packet;
        port_id_t  cur_port;
        if (reset) begin
            in_packet = 1'b0;
        end else if (out_vld && out_rdy) begin
            port = out_meta[OUT_META_WID-1 -: PORT_WID];
            if (in_packet && port != cur_port) begin
                report_failure("output switched ports before the eop beat");
            end
            if ((port == 0 && exp_q0.size() == 0) || (port == 1 && exp_q1.size() == 0)) begin
                report_failure($sformatf("unexpected beat from port %0d", port));
            end else begin
                if (port == 0) begin
                    want = exp_q0.pop_front();
                end else begin
                    want = exp_q1.pop_front();
                end
                compare_beat(want);
            end
            in_packet = !out_eop;
            cur_port  = port;
            if (out_eop) begin
                packet_ports.push_back(int'(port));
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        report_failure($sformatf("timeout after %0d cycles, tests did not finish",
                                 TIMEOUT_CYCLES));
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        seed         = 95885;
        error_count  = 0;
        check_count  = 0;
        traffic_done = 1'b0;
        reset        = 1'b1;
        in0_vld      = 1'b0;
        in0_data     = '0;
        in0_eop      = 1'b0;
        in0_mty      = '0;
        in0_err      = 1'b0;
        in0_meta     = '0;
        in1_vld      = 1'b0;
        in1_data     = '0;
        in1_eop      = 1'b0;
        in1_mty      = '0;
        in1_err      = 1'b0;
        in1_meta     = '0;
        out_rdy      = 1'b0;
        apply_reset();
        test_single_packet();
        test_round_robin();
        test_random_backpressure();
        test_fifo_full();
        test_err_and_mty();
        if (exp_q0.size() != 0) begin
            report_failure($sformatf("port 0 still had %0d beats pending", exp_q0.size()));
        end
        if (exp_q1.size() != 0) begin
            report_failure($sformatf("port 1 still had %0d beats pending", exp_q1.size()));
        end
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : pkt_aggregator_tb

`default_nettype wire

//--- pkt_aggregator.f
source/pkt_pkg.sv
source/packet_intf.sv
source/packet_fifo.sv
source/packet_merge.sv
source/pkt_aggregator.sv
verification/tb_clock.sv
verification/pkt_aggregator_tb.sv

//--- Makefile
TOP := pkt_aggregator_tb

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f pkt_aggregator.f -o sim
	./obj_dir/sim | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null

clean:
	rm -rf obj_dir
